// ==== common/cache_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths, AXI codes and state encodings of the read-only cache
// imported by every cache module and by the verification files
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package cache_pkg;

   localparam int ADDR_W       = 16;   // byte address
   localparam int WORD_W       = 32;   // cache word, also one AXI beat
   localparam int WORD_BYTES_W = 2;    // byte offset inside a word

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [ADDR_W-1:0] addr_t;

   typedef logic [7:0] axi_len_t;
   typedef logic [2:0] axi_size_t;
   typedef logic [1:0] axi_burst_t;
   typedef logic [1:0] axi_resp_t;
   typedef logic [3:0] axi_id_t;

   localparam axi_id_t    AXI_ID        = 4'd0;
   localparam axi_burst_t BURST_FIXED   = 2'b00;
   localparam axi_burst_t BURST_INCR    = 2'b01;
   localparam axi_resp_t  RESP_OKAY     = 2'b00;
   localparam logic [3:0] CACHE_BITS_RO = 4'b0011;   // cacheable, bufferable

   // line refill engine
   typedef enum logic [1:0] {
      RF_IDLE,
      RF_ADDR,
      RF_LOAD,
      RF_END
   } refill_state_e;

   // tag lookup and miss sequencing
   typedef enum logic [2:0] {
      LK_IDLE,
      LK_READ,
      LK_MISS,
      LK_WAIT,
      LK_DONE
   } lookup_state_e;

endpackage

`default_nettype wire

// ==== source/cache_front.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// requester port of the cache with a four-phase req/ack handshake
// one read in flight, address and result held stable while ack is up
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module cache_front (
   input  logic              clk_i,
   input  logic              reset_i,
   input  logic              req_i,
   input  cache_pkg::addr_t  addr_i,
   output logic              ack_o,
   output cache_pkg::word_t  rdata_o,
   output logic              lk_start_o,
   output cache_pkg::addr_t  lk_addr_o,
   input  logic              lk_done_i,
   input  cache_pkg::word_t  lk_word_i
);
   import cache_pkg::*;

   typedef enum logic [1:0] {
      FR_IDLE,    // waiting for req
      FR_START,   // lookup kicked off
      FR_WAIT,    // lookup busy
      FR_ACK      // ack held until req drops
   } front_state_e;

   front_state_e state_q;
   addr_t        addr_q;
   word_t        word_q;

   always_ff @(posedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         state_q <= FR_IDLE;
      end else begin
         case (state_q)
            FR_IDLE:  if (req_i) state_q <= FR_START;
            FR_START: state_q <= FR_WAIT;
            FR_WAIT:  if (lk_done_i) state_q <= FR_ACK;
            FR_ACK:   if (!req_i) state_q <= FR_IDLE;   // end of the four phases
            default:  state_q <= FR_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == FR_IDLE && req_i) addr_q <= addr_i;
      if (state_q == FR_WAIT && lk_done_i) word_q <= lk_word_i;
   end

   assign lk_start_o = (state_q == FR_START);
   assign lk_addr_o  = addr_q;
   assign ack_o      = (state_q == FR_ACK);
   assign rdata_o    = word_q;

endmodule

`default_nettype wire

// ==== source/cache_lookup.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tag and valid arrays of the direct-mapped cache, hit check and miss flow
// a miss asks the refill engine for the line, then rereads it like a hit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module cache_lookup #(
   parameter int INDEX_W  = 3,
   parameter int OFFSET_W = 2
) (
   input  logic                                  clk_i,
   input  logic                                  reset_i,
   input  logic                                  lk_start_i,
   input  cache_pkg::addr_t                      lk_addr_i,
   output logic                                  lk_done_o,
   output cache_pkg::word_t                      lk_word_o,
   output logic                                  replace_valid_o,
   output logic [cache_pkg::ADDR_W-OFFSET_W-cache_pkg::WORD_BYTES_W-1:0] replace_addr_o,
   input  logic                                  replace_i,
   output logic                                  rd_en_o,
   output logic [INDEX_W-1:0]                    rd_index_o,
   output logic [((OFFSET_W > 0) ? OFFSET_W : 1)-1:0] rd_offset_o,
   input  cache_pkg::word_t                      rd_data_i,
   input  logic                                  fill_valid_i
);
   import cache_pkg::*;

   localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W - WORD_BYTES_W;
   localparam int OFF_W = (OFFSET_W > 0) ? OFFSET_W : 1;
   localparam int LINES = 2 ** INDEX_W;

   lookup_state_e       state_q;
   addr_t               addr_q;
   logic [LINES-1:0]    valid_q;
   logic [TAG_W-1:0]    tag_q [LINES];

   logic [TAG_W-1:0]    tag;
   logic [INDEX_W-1:0]  index;
   logic [OFF_W-1:0]    offset;
   logic                hit;

   // split the registered address into its fields
   assign tag    = addr_q[ADDR_W-1 -: TAG_W];
   assign index  = addr_q[WORD_BYTES_W+OFFSET_W +: INDEX_W];
   assign offset = (OFFSET_W > 0) ? addr_q[WORD_BYTES_W +: OFF_W] : '0;

   assign hit = valid_q[index] && (tag_q[index] == tag);

   always_ff @(posedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         state_q <= LK_IDLE;
         valid_q <= '0;
      end else begin
         case (state_q)
            LK_IDLE: if (lk_start_i) state_q <= LK_READ;
            LK_READ: state_q <= hit ? LK_WAIT : LK_MISS;
            LK_MISS: begin
               // a line being overwritten is never reported as a hit
               if (fill_valid_i) valid_q[index] <= 1'b0;
               if (!replace_i) begin
                  valid_q[index] <= 1'b1;
                  state_q        <= LK_READ;   // reread the fresh line
               end
            end
            LK_WAIT: state_q <= LK_DONE;     // store read in progress
            LK_DONE: state_q <= LK_IDLE;
            default: state_q <= LK_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == LK_IDLE && lk_start_i) addr_q <= lk_addr_i;
      if (state_q == LK_MISS && !replace_i) tag_q[index] <= tag;
      if (state_q == LK_WAIT) lk_word_o <= rd_data_i;
   end

   assign rd_en_o         = (state_q == LK_READ) && hit;
   assign rd_index_o      = index;   // also selects the line written by the refill
   assign rd_offset_o     = offset;
   assign replace_valid_o = (state_q == LK_READ) && !hit;
   assign replace_addr_o  = addr_q[ADDR_W-1:OFFSET_W+WORD_BYTES_W];
   assign lk_done_o       = (state_q == LK_DONE);

endmodule

`default_nettype wire

// ==== source/cache_line_store.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// word memory holding the cache lines, one write and one registered read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module cache_line_store #(
   parameter int INDEX_W  = 3,
   parameter int OFFSET_W = 2
) (
   input  logic                                        clk_i,
   input  logic                                        wr_en_i,
   input  logic [INDEX_W-1:0]                          wr_index_i,
   input  logic [((OFFSET_W > 0) ? OFFSET_W : 1)-1:0]  wr_offset_i,
   input  cache_pkg::word_t                            wr_data_i,
   input  logic                                        rd_en_i,
   input  logic [INDEX_W-1:0]                          rd_index_i,
   input  logic [((OFFSET_W > 0) ? OFFSET_W : 1)-1:0]  rd_offset_i,
   output cache_pkg::word_t                            rd_data_o
);
   import cache_pkg::*;

   localparam int OFF_W = (OFFSET_W > 0) ? OFFSET_W : 1;
   localparam int DEPTH = 2 ** (INDEX_W + OFFSET_W);

   word_t                    mem [DEPTH];
   logic [INDEX_W+OFF_W-1:0] wr_addr;
   logic [INDEX_W+OFF_W-1:0] rd_addr;

   // the shift drops the dummy offset bit of one-word lines
   assign wr_addr = {wr_index_i, wr_offset_i} >> (OFF_W - OFFSET_W);
   assign rd_addr = {rd_index_i, rd_offset_i} >> (OFF_W - OFFSET_W);

   always_ff @(posedge clk_i) begin
      if (wr_en_i) mem[wr_addr[INDEX_W+OFFSET_W-1:0]] <= wr_data_i;
      if (rd_en_i) rd_data_o <= mem[rd_addr[INDEX_W+OFFSET_W-1:0]];   // held until next read
   end

endmodule

`default_nettype wire

// ==== refill/cache_refill_axi.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4 read master that refills one cache line per request
// a burst with any error response is repeated once it has finished
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module cache_refill_axi #(
   parameter int INDEX_W  = 3,
   parameter int OFFSET_W = 2
) (
   input  logic                                        clk_i,
   input  logic                                        reset_i,
   input  logic                                        replace_valid_i,
   input  logic [cache_pkg::ADDR_W-OFFSET_W-cache_pkg::WORD_BYTES_W-1:0] replace_addr_i,
   output logic                                        replace_o,
   output logic                                        fill_valid_o,
   output logic [((OFFSET_W > 0) ? OFFSET_W : 1)-1:0]  fill_offset_o,
   output cache_pkg::word_t                            fill_data_o,
   output logic                                        axi_arvalid_o,
   input  logic                                        axi_arready_i,
   output cache_pkg::addr_t                            axi_araddr_o,
   output cache_pkg::axi_id_t                          axi_arid_o,
   output cache_pkg::axi_len_t                         axi_arlen_o,
   output cache_pkg::axi_size_t                        axi_arsize_o,
   output cache_pkg::axi_burst_t                       axi_arburst_o,
   output logic                                        axi_arlock_o,
   output logic [3:0]                                  axi_arcache_o,
   output logic [2:0]                                  axi_arprot_o,
   output logic [3:0]                                  axi_arqos_o,
   input  logic                                        axi_rvalid_i,
   output logic                                        axi_rready_o,
   input  cache_pkg::word_t                            axi_rdata_i,
   input  cache_pkg::axi_resp_t                        axi_rresp_i,
   input  logic                                        axi_rlast_i
);
   import cache_pkg::*;

   localparam int TAG_W  = ADDR_W - INDEX_W - OFFSET_W - WORD_BYTES_W;
   localparam int LINE_W = TAG_W + INDEX_W;   // tag and index make the line address

   refill_state_e     state_q;
   refill_state_e     state_d;
   logic [LINE_W-1:0] line_q;
   logic              beat;

   always_ff @(posedge clk_i or posedge reset_i) begin
      if (reset_i) state_q <= RF_IDLE;
      else state_q <= state_d;
   end

   // keep the line address for the retries
   always_ff @(posedge clk_i) begin
      if (state_q == RF_IDLE && replace_valid_i) line_q <= replace_addr_i;
   end

   assign axi_arid_o    = AXI_ID;
   assign axi_arlock_o  = 1'b0;
   assign axi_arcache_o = CACHE_BITS_RO;
   assign axi_arprot_o  = 3'd0;
   assign axi_arqos_o   = 4'd0;
   assign axi_arsize_o  = axi_size_t'(WORD_BYTES_W);   // one word per beat
   assign axi_araddr_o  = {line_q, {(OFFSET_W + WORD_BYTES_W){1'b0}}};

   assign replace_o     = (state_q != RF_IDLE);
   assign axi_arvalid_o = (state_q == RF_ADDR);
   assign axi_rready_o  = (state_q == RF_LOAD);
   assign beat          = axi_rvalid_i && axi_rready_o;
   assign fill_valid_o  = beat;
   assign fill_data_o   = axi_rdata_i;

   generate
      if (OFFSET_W > 0) begin : g_burst
         logic [OFFSET_W-1:0] offset_q;
         logic                slave_err_q;   // sticky, the burst cannot be cut short

         assign axi_arlen_o   = axi_len_t'(2 ** OFFSET_W - 1);
         assign axi_arburst_o = BURST_INCR;
         assign fill_offset_o = offset_q;

         always_ff @(posedge clk_i or posedge reset_i) begin
            if (reset_i) begin
               offset_q    <= '0;
               slave_err_q <= 1'b0;
            end else if (state_q == RF_ADDR) begin
               offset_q    <= '0;
               slave_err_q <= 1'b0;
            end else if (beat) begin
               offset_q <= offset_q + 1'b1;
               if (axi_rresp_i != RESP_OKAY) slave_err_q <= 1'b1;
            end
         end

         always_comb begin
            state_d = state_q;
            case (state_q)
               RF_IDLE: if (replace_valid_i) state_d = RF_ADDR;
               RF_ADDR: if (axi_arready_i) state_d = RF_LOAD;
               RF_LOAD: if (beat && axi_rlast_i) state_d = RF_END;
               RF_END:  state_d = slave_err_q ? RF_ADDR : RF_IDLE;   // last write settles
               default: state_d = RF_IDLE;
            endcase
         end
      end else begin : g_single
         assign axi_arlen_o   = '0;
         assign axi_arburst_o = BURST_FIXED;
         assign fill_offset_o = '0;

         // single beat, so an error can retry straight away
         always_comb begin
            state_d = state_q;
            case (state_q)
               RF_IDLE: if (replace_valid_i) state_d = RF_ADDR;
               RF_ADDR: if (axi_arready_i) state_d = RF_LOAD;
               RF_LOAD: if (beat) state_d = (axi_rresp_i != RESP_OKAY) ? RF_ADDR : RF_END;
               RF_END:  state_d = RF_IDLE;
               default: state_d = RF_IDLE;
            endcase
         end
      end
   endgenerate

endmodule

`default_nettype wire

// ==== source/cache_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// read-only direct-mapped cache, requester port in and AXI4 read master out
// geometry is set here and passed down to every block
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module cache_top #(
   parameter int INDEX_W  = 3,   // 8 lines
   parameter int OFFSET_W = 2    // 4 words per line
) (
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  req_i,
   input  cache_pkg::addr_t      addr_i,
   output logic                  ack_o,
   output cache_pkg::word_t      rdata_o,
   output logic                  axi_arvalid_o,
   input  logic                  axi_arready_i,
   output cache_pkg::addr_t      axi_araddr_o,
   output cache_pkg::axi_id_t    axi_arid_o,
   output cache_pkg::axi_len_t   axi_arlen_o,
   output cache_pkg::axi_size_t  axi_arsize_o,
   output cache_pkg::axi_burst_t axi_arburst_o,
   output logic                  axi_arlock_o,
   output logic [3:0]            axi_arcache_o,
   output logic [2:0]            axi_arprot_o,
   output logic [3:0]            axi_arqos_o,
   input  logic                  axi_rvalid_i,
   output logic                  axi_rready_o,
   input  cache_pkg::word_t      axi_rdata_i,
   input  cache_pkg::axi_resp_t  axi_rresp_i,
   input  logic                  axi_rlast_i
);
   import cache_pkg::*;

   localparam int OFF_W  = (OFFSET_W > 0) ? OFFSET_W : 1;
   localparam int LINE_W = ADDR_W - OFFSET_W - WORD_BYTES_W;

   logic              lk_start;
   addr_t             lk_addr;
   logic              lk_done;
   word_t             lk_word;
   logic              replace_valid;
   logic [LINE_W-1:0] replace_addr;
   logic              replace;
   logic              rd_en;
   logic [INDEX_W-1:0] rd_index;
   logic [OFF_W-1:0]  rd_offset;
   word_t             rd_data;
   logic              fill_valid;
   logic [OFF_W-1:0]  fill_offset;
   word_t             fill_data;

   cache_front u_front (
      .clk_i, .reset_i, .req_i, .addr_i, .ack_o, .rdata_o,
      .lk_start_o(lk_start), .lk_addr_o(lk_addr), .lk_done_i(lk_done), .lk_word_i(lk_word)
   );

   cache_lookup #(.INDEX_W(INDEX_W), .OFFSET_W(OFFSET_W)) u_lookup (
      .clk_i, .reset_i,
      .lk_start_i(lk_start), .lk_addr_i(lk_addr), .lk_done_o(lk_done), .lk_word_o(lk_word),
      .replace_valid_o(replace_valid), .replace_addr_o(replace_addr), .replace_i(replace),
      .rd_en_o(rd_en), .rd_index_o(rd_index), .rd_offset_o(rd_offset), .rd_data_i(rd_data),
      .fill_valid_i(fill_valid)
   );

   // the refill writes into the line the lookup is holding
   cache_line_store #(.INDEX_W(INDEX_W), .OFFSET_W(OFFSET_W)) u_store (
      .clk_i,
      .wr_en_i(fill_valid), .wr_index_i(rd_index), .wr_offset_i(fill_offset),
      .wr_data_i(fill_data),
      .rd_en_i(rd_en), .rd_index_i(rd_index), .rd_offset_i(rd_offset), .rd_data_o(rd_data)
   );

   cache_refill_axi #(.INDEX_W(INDEX_W), .OFFSET_W(OFFSET_W)) u_refill (
      .clk_i, .reset_i,
      .replace_valid_i(replace_valid), .replace_addr_i(replace_addr), .replace_o(replace),
      .fill_valid_o(fill_valid), .fill_offset_o(fill_offset), .fill_data_o(fill_data),
      .axi_arvalid_o, .axi_arready_i, .axi_araddr_o, .axi_arid_o, .axi_arlen_o,
      .axi_arsize_o, .axi_arburst_o, .axi_arlock_o, .axi_arcache_o, .axi_arprot_o,
      .axi_arqos_o, .axi_rvalid_i, .axi_rready_o, .axi_rdata_i, .axi_rresp_i, .axi_rlast_i
   );

endmodule

`default_nettype wire

// ==== test/cache_asserts.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI read protocol checks, bound into every refill engine instance
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module cache_asserts (
   input logic                     clk_i,
   input logic                     reset_i,
   input cache_pkg::refill_state_e state_i,
   input logic                     arvalid_i,
   input logic                     arready_i,
   input cache_pkg::addr_t         araddr_i,
   input logic                     rready_i,
   input logic                     replace_i
);
   import cache_pkg::*;

   // AR request held with a stable address until it is taken
   a_ar_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
      else $error("arvalid dropped or araddr changed before arready");

   a_no_rready_in_addr: assert property (@(posedge clk_i) disable iff (reset_i)
      state_i == RF_ADDR |-> !rready_i)
      else $error("rready high while the AR request is pending");

   a_idle_no_replace: assert property (@(posedge clk_i) disable iff (reset_i)
      state_i == RF_IDLE |-> !replace_i)   // refill busy flag
      else $error("replace high while the refill engine is idle");

endmodule

`default_nettype wire

// ==== test/tb_cache.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench of the read-only cache: random reads against an AXI slave model
// with stalls and error responses, checked against a memory and tag model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module tb_cache;
   import cache_pkg::*;

   localparam int unsigned SEED       = 32'h4584_250a;
   localparam int NUM_READS           = 200;
   localparam int MEM_WORDS           = 64;   // several lines share each set
   localparam int LINE_BYTES          = 16;
   localparam int LINES               = 8;
   localparam int RESET_CYCLES        = 4;
   localparam int TIMEOUT_CYCLES      = NUM_READS * 60;
   localparam axi_resp_t RESP_SLVERR  = 2'b10;

   logic       clk_i;
   logic       reset_i;
   logic       req_i;
   addr_t      addr_i;
   logic       ack_o;
   word_t      rdata_o;
   logic       axi_arvalid_o;
   logic       axi_arready_i;
   addr_t      axi_araddr_o;
   axi_id_t    axi_arid_o;
   axi_len_t   axi_arlen_o;
   axi_size_t  axi_arsize_o;
   axi_burst_t axi_arburst_o;
   logic       axi_arlock_o;
   logic [3:0] axi_arcache_o;
   logic [2:0] axi_arprot_o;
   logic [3:0] axi_arqos_o;
   logic       axi_rvalid_i;
   logic       axi_rready_o;
   word_t      axi_rdata_i;
   axi_resp_t  axi_rresp_i;
   logic       axi_rlast_i;

   word_t            mem [MEM_WORDS];
   logic [LINES-1:0] model_valid;
   int               model_tag [LINES];
   addr_t            cur_addr;
   int               errs [1:6];   // per behavior
   int               ar_count;
   int               err_count;
   int               miss_count;
   int               cycle_count;
   bit               retry_pending;

   bind cache_refill_axi cache_asserts u_asserts (
      .clk_i(clk_i), .reset_i(reset_i), .state_i(state_q),
      .arvalid_i(axi_arvalid_o), .arready_i(axi_arready_i), .araddr_i(axi_araddr_o),
      .rready_i(axi_rready_o), .replace_i(replace_o)
   );

   cache_top dut_i (
      .clk_i, .reset_i, .req_i, .addr_i, .ack_o, .rdata_o,
      .axi_arvalid_o, .axi_arready_i, .axi_araddr_o, .axi_arid_o, .axi_arlen_o,
      .axi_arsize_o, .axi_arburst_o, .axi_arlock_o, .axi_arcache_o, .axi_arprot_o,
      .axi_arqos_o, .axi_rvalid_i, .axi_rready_o, .axi_rdata_i, .axi_rresp_i, .axi_rlast_i
   );

   always #50 clk_i = ~clk_i;

   always @(posedge clk_i) begin
      cycle_count++;
      if (cycle_count > TIMEOUT_CYCLES) begin
         $display("run timed out after %0d cycles", cycle_count);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   task automatic tick();
      @(posedge clk_i);
      #1;   // inputs change just after the edge
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp,
                             input int id);
      if (got !== exp) begin
         $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
         errs[id]++;
      end
   endtask

   task automatic check_addr(input string name, input addr_t got, input addr_t exp,
                             input int id);
      if (got !== exp) begin
         $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
         errs[id]++;
      end
   endtask

   task automatic check_len(input string name, input axi_len_t got, input axi_len_t exp,
                            input int id);
      if (got !== exp) begin
         $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
         errs[id]++;
      end
   endtask

   // one burst per call, arready and each beat come after 0 to 3 idle cycles
   task automatic serve_burst();
      addr_t base;
      int    beats;
      int    err_beat;
      int    b;
      bit    inject;
      bit    accepted;
      do @(negedge clk_i); while (axi_arvalid_o !== 1'b1);
      base  = axi_araddr_o;
      beats = int'(axi_arlen_o) + 1;
      check_addr("axi_araddr_o", axi_araddr_o, addr_t'(cur_addr / LINE_BYTES * LINE_BYTES), 4);
      check_len("axi_arlen_o", axi_arlen_o, axi_len_t'(LINE_BYTES / 4 - 1), 4);
      if (axi_arburst_o !== BURST_INCR || axi_arsize_o !== 3'd2) begin
         $display("Mismatch axi_arburst_o/axi_arsize_o: got 0x%h/0x%h, expected 0x%h/0x2",
                  axi_arburst_o, axi_arsize_o, BURST_INCR);
         errs[4]++;
      end
      if (axi_arid_o !== AXI_ID || axi_arcache_o !== 4'b0011) begin
         $display("Mismatch axi_arid_o/axi_arcache_o: got 0x%h/0x%h, expected 0x%h/0x3",
                  axi_arid_o, axi_arcache_o, AXI_ID);
         errs[4]++;
      end
      if (axi_arlock_o !== 1'b0 || axi_arprot_o !== 3'd0 || axi_arqos_o !== 4'd0) begin
         $display(
            "Mismatch axi_arlock_o/axi_arprot_o/axi_arqos_o: got 0x%h/0x%h/0x%h, expected 0x0",
            axi_arlock_o, axi_arprot_o, axi_arqos_o);
         errs[4]++;
      end
      tick();
      repeat ($urandom_range(3, 0)) tick();
      axi_arready_i = 1'b1;
      tick();   // arvalid is held, so the request is taken here
      axi_arready_i = 1'b0;
      ar_count++;
      inject   = !retry_pending && ($urandom_range(7, 0) == 0);   // first attempts only
      err_beat = $urandom_range(beats - 1, 0);
      for (b = 0; b < beats; b++) begin
         repeat ($urandom_range(3, 0)) tick();
         axi_rvalid_i = 1'b1;
         axi_rdata_i  = mem[((base >> 2) + b) % MEM_WORDS];
         axi_rresp_i  = RESP_OKAY;
         axi_rlast_i  = (b == beats - 1);
         if (inject && b == err_beat) begin
            axi_rdata_i = ~axi_rdata_i;   // bad data travels with the error
            axi_rresp_i = RESP_SLVERR;
         end
         do begin
            @(negedge clk_i);
            accepted = (axi_rready_o === 1'b1);
            tick();
         end while (!accepted);
         axi_rvalid_i = 1'b0;
         axi_rlast_i  = 1'b0;
         axi_rresp_i  = RESP_OKAY;
      end
      if (inject) err_count++;
      retry_pending = inject;
   endtask

   task automatic do_read(input addr_t addr);
      int ar_before;
      int err_before;
      int cycles;
      int index;
      int tag;
      bit exp_hit;
      index      = (addr / LINE_BYTES) % LINES;
      tag        = addr / (LINE_BYTES * LINES);
      exp_hit    = model_valid[index] && model_tag[index] == tag;
      ar_before  = ar_count;
      err_before = err_count;
      cycles     = 0;
      tick();
      cur_addr = addr;
      req_i    = 1'b1;
      addr_i   = addr;
      @(posedge clk_i);   // front end takes the request here
      do begin
         @(posedge clk_i);
         cycles++;
         @(negedge clk_i);
      end while (ack_o !== 1'b1);
      check_word("rdata_o", rdata_o, mem[(addr >> 2) % MEM_WORDS],
                 (err_count > err_before) ? 5 : 2);
      if (exp_hit) begin
         if (cycles != 4 || ar_count != ar_before) begin
            $display("hit at 0x%h took %0d cycles and %0d AR requests, expected 4 and none",
                     addr, cycles, ar_count - ar_before);
            errs[3]++;
         end
      end else begin
         miss_count++;
         if (ar_count - ar_before != 1 + err_count - err_before) begin
            $display("miss at 0x%h made %0d AR requests after %0d error responses",
                     addr, ar_count - ar_before, err_count - err_before);
            errs[(err_count > err_before) ? 5 : 3]++;
         end
      end
      model_valid[index] = 1'b1;
      model_tag[index]   = tag;
      repeat ($urandom_range(3, 0)) begin   // requester keeps req up a while
         @(negedge clk_i);
         if (ack_o !== 1'b1) begin
            $display("ack_o fell at 0x%h while req_i was still high", addr);
            errs[6]++;
         end
      end
      tick();
      req_i = 1'b0;
      @(negedge clk_i);
      @(negedge clk_i);
      if (ack_o !== 1'b0) begin
         $display("ack_o still high one cycle after req_i fell at 0x%h", addr);
         errs[6]++;
      end
   endtask

   task automatic report_test(input int id, input string name);
      if (errs[id] == 0) $display("test %0d, %s: ok", id, name);
      else $display("test %0d, %s: %0d errors", id, name, errs[id]);
   endtask

   initial begin
      int unsigned seed_ret;
      int          total;
      int          n;
      seed_ret      = $urandom(SEED);
      clk_i         = 1'b0;
      reset_i       = 1'b1;
      req_i         = 1'b0;
      addr_i        = '0;
      axi_arready_i = 1'b0;
      axi_rvalid_i  = 1'b0;
      axi_rdata_i   = '0;
      axi_rresp_i   = RESP_OKAY;
      axi_rlast_i   = 1'b0;
      model_valid   = '0;
      foreach (mem[i]) mem[i] = $urandom();
      repeat (RESET_CYCLES) @(posedge clk_i);
      #1 reset_i = 1'b0;
      @(negedge clk_i);
      if (ack_o !== 1'b0 || axi_arvalid_o !== 1'b0 || axi_rready_o !== 1'b0) begin
         $display("ack_o, axi_arvalid_o or axi_rready_o not low after reset");
         errs[1]++;
      end
      report_test(1, "idle outputs after reset");
      for (n = 0; n < NUM_READS; n++) begin
         do_read(addr_t'($urandom_range(MEM_WORDS - 1, 0) * 4));
      end
      report_test(2, "read data on hits and misses");
      report_test(3, "AR requests only on misses, hit latency");
      report_test(4, "AR address, length, burst and size");
      report_test(5, "burst retry after error response");
      report_test(6, "ack held while req is high");
      total = 0;
      foreach (errs[i]) total += errs[i];
      $display("%0d reads, %0d misses, %0d error responses, %0d errors",
               NUM_READS, miss_count, err_count, total);
      if (total == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

   // slave model serves bursts for the whole run
   initial begin
      @(negedge reset_i);
      forever serve_burst();
   end

endmodule

`default_nettype wire

// ==== tb.f ====
common/cache_pkg.sv
source/cache_front.sv
source/cache_lookup.sv
source/cache_line_store.sv
refill/cache_refill_axi.sv
source/cache_top.sv
test/cache_asserts.sv
test/tb_cache.sv
